//--- hw/mask_defines.svh
// Image geometry, mask address width and input FIFO depth macros

`ifndef MASK_DEFINES_SVH
`define MASK_DEFINES_SVH

// Frame geometry, kept small for simulation
`define MASK_WIDTH  8   // Pixels per row
`define MASK_HEIGHT 6   // Rows per frame

// Total mask words, one per pixel
`define MASK_SIZE (`MASK_WIDTH * `MASK_HEIGHT)

// Bits needed to address every mask word
`define MASK_ADDR_BITS $clog2(`MASK_SIZE)

// Input FIFO entries, must be a power of two
`define PIXEL_FIFO_DEPTH 16

`endif

//--- hw/image_pkg.sv
// Pixel and gray-level types for the mask capture datapath

`default_nettype none

package image_pkg;

    // One color channel
    typedef logic [7:0] channel_t;

    // Packed RGB pixel, red in the upper byte
    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } rgb_pixel_t;

    // Gray level stored in the mask
    typedef logic [7:0] gray_t;

endpackage

`default_nettype wire

//--- hw/mask_ctrl_pkg.sv
// State encoding for the mask writer FSM

`default_nettype none

package mask_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,   // Waiting for the first pixel of a frame
        GS,     // Pop a pixel and average it
        OUTPUT  // Write the average into the mask
    } mask_state_t;

endpackage

`default_nettype wire

//--- hw/pixel_fifo.sv
// pixel_fifo: first-word-fall-through FIFO for incoming RGB pixels

`timescale 1ns/1ps
`default_nettype none

`include "mask_defines.svh"

module pixel_fifo
    import image_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    // Write side
    input  logic       wr_en,
    input  rgb_pixel_t din,
    output logic       full,
    // Read side
    input  logic       rd_en,
    output rgb_pixel_t dout,
    output logic       empty
);

    localparam int DEPTH    = `PIXEL_FIFO_DEPTH;
    localparam int IDX_BITS = $clog2(DEPTH);

    rgb_pixel_t mem [0:DEPTH-1];

    // Extra MSB tells a full buffer from an empty one
    logic [IDX_BITS:0] wr_ptr;
    logic [IDX_BITS:0] rd_ptr;

    logic do_write;
    logic do_read;

    assign do_write = wr_en && !full;   // Writes while full are dropped
    assign do_read  = rd_en && !empty;  // Reads while empty are ignored

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[IDX_BITS] != rd_ptr[IDX_BITS]) &&
                   (wr_ptr[IDX_BITS-1:0] == rd_ptr[IDX_BITS-1:0]);

    // Oldest entry is always visible on the read side
    assign dout = mem[rd_ptr[IDX_BITS-1:0]];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Pixel storage
    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[IDX_BITS-1:0]] <= din;
        end
    end

endmodule

`default_nettype wire

//--- hw/grayscale_mask.sv
// grayscale_mask: pops RGB pixels, averages the channels, writes the mask in raster order

`timescale 1ns/1ps
`default_nettype none

`include "mask_defines.svh"

module grayscale_mask
    import image_pkg::*;
    import mask_ctrl_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    // Input FIFO read side
    output logic                       in_rd_en,
    input  logic                       in_empty,
    input  rgb_pixel_t                 in_dout,
    // Mask memory write side
    output logic                       out_wr_en,
    output logic [`MASK_ADDR_BITS-1:0] out_wr_addr,
    output gray_t                      out_wr_data,
    // High while a frame is being written
    output logic                       busy
);

    localparam int ADDR_BITS = `MASK_ADDR_BITS;
    localparam int COL_BITS  = $clog2(`MASK_WIDTH);
    localparam int ROW_BITS  = $clog2(`MASK_HEIGHT);

    mask_state_t state;
    mask_state_t next_state;

    gray_t gs;
    gray_t gs_c;

    // Raster position of the next mask write
    logic [COL_BITS-1:0] col;
    logic [COL_BITS-1:0] col_c;
    logic [ROW_BITS-1:0] row;
    logic [ROW_BITS-1:0] row_c;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            col   <= '0;
            row   <= '0;
        end else begin
            state <= next_state;
            col   <= col_c;
            row   <= row_c;
        end
    end

    // Averaged pixel, only meaningful in OUTPUT
    always_ff @(posedge clock) begin
        gs <= gs_c;
    end

    assign busy        = (state != IDLE);
    assign out_wr_data = gs;
    assign out_wr_addr = ADDR_BITS'(row * `MASK_WIDTH + col);

    always_comb begin
        in_rd_en   = 1'b0;
        out_wr_en  = 1'b0;
        next_state = state;
        gs_c       = gs;
        col_c      = col;
        row_c      = row;

        case (state)
            IDLE: begin
                // New frame starts at address zero
                if (!in_empty) begin
                    next_state = GS;
                    col_c      = '0;
                    row_c      = '0;
                end
            end
            GS: begin
                if (!in_empty) begin
                    // Ten bits hold the sum of three bytes
                    gs_c = gray_t'(({2'b00, in_dout.red} + {2'b00, in_dout.green} +
                                    {2'b00, in_dout.blue}) / 10'd3);
                    in_rd_en   = 1'b1;
                    next_state = OUTPUT;
                end
            end
            OUTPUT: begin
                out_wr_en  = 1'b1;
                next_state = GS;
                if (col == COL_BITS'(`MASK_WIDTH - 1)) begin
                    if (row == ROW_BITS'(`MASK_HEIGHT - 1)) begin
                        next_state = IDLE;  // Last pixel of the frame
                    end else begin
                        col_c = '0;
                        row_c = row + 1'b1;
                    end
                end else begin
                    col_c = col + 1'b1;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/mask_bram.sv
// mask_bram: mask memory with one write port and one registered read port

`timescale 1ns/1ps
`default_nettype none

`include "mask_defines.svh"

module mask_bram
    import image_pkg::*;
(
    input  logic                       clock,
    // Write port
    input  logic                       wr_en,
    input  logic [`MASK_ADDR_BITS-1:0] wr_addr,
    input  gray_t                      wr_data,
    // Read port, one cycle latency
    input  logic [`MASK_ADDR_BITS-1:0] rd_addr,
    output gray_t                      rd_data
);

    localparam int WORDS = `MASK_SIZE;

    // One gray level per pixel
    gray_t mem [0:WORDS-1];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read so synthesis maps this onto block RAM
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- hw/mask_capture_top.sv
// mask_capture_top: input FIFO, mask writer and mask memory behind plain ports

`timescale 1ns/1ps
`default_nettype none

`include "mask_defines.svh"

module mask_capture_top
    import image_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    // Pixel input, raster order
    input  logic                       in_wr_en,
    input  logic [23:0]                in_din,
    output logic                       in_full,
    // Mask read port
    input  logic [`MASK_ADDR_BITS-1:0] mask_rd_addr,
    output logic [7:0]                 mask_rd_data,
    // Frame in progress
    output logic                       busy
);

    // FIFO to mask writer
    logic       fifo_empty;
    logic       fifo_rd_en;
    rgb_pixel_t fifo_dout;

    // Mask writer to memory
    logic                       mask_wr_en;
    logic [`MASK_ADDR_BITS-1:0] mask_wr_addr;
    gray_t                      mask_wr_data;

    pixel_fifo u_pixel_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (rgb_pixel_t'(in_din)),  // Red in bits 23:16
        .full  (in_full),
        .rd_en (fifo_rd_en),
        .dout  (fifo_dout),
        .empty (fifo_empty)
    );

    grayscale_mask u_grayscale_mask (
        .clock       (clock),
        .reset       (reset),
        .in_rd_en    (fifo_rd_en),
        .in_empty    (fifo_empty),
        .in_dout     (fifo_dout),
        .out_wr_en   (mask_wr_en),
        .out_wr_addr (mask_wr_addr),
        .out_wr_data (mask_wr_data),
        .busy        (busy)
    );

    mask_bram u_mask_bram (
        .clock   (clock),
        .wr_en   (mask_wr_en),
        .wr_addr (mask_wr_addr),
        .wr_data (mask_wr_data),
        .rd_addr (mask_rd_addr),
        .rd_data (mask_rd_data)
    );

endmodule

`default_nettype wire

//--- tests/mask_capture_checker.sv
// Concurrent assertions on the pixel FIFO and the mask writer, with their bind statements

`timescale 1ns/1ps
`default_nettype none

`include "mask_defines.svh"

module mask_capture_checker
    import mask_ctrl_pkg::*;
(
    input logic                       clock,
    input logic                       reset,
    input logic                       push,
    input logic                       full,
    input logic                       pop,
    input logic                       empty,
    input logic                       wr_en,
    input logic [`MASK_ADDR_BITS-1:0] wr_addr,
    input mask_state_t                state
);

    localparam int ADDR_BITS = `MASK_ADDR_BITS;
    localparam logic [ADDR_BITS-1:0] LAST_ADDR = ADDR_BITS'(`MASK_SIZE - 1);

    no_write_when_full: assert property (@(posedge clock) disable iff (reset)
        !(push && full)) else $error("write strobe while the FIFO is full");

    no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
        !(pop && empty)) else $error("pop while the FIFO is empty");

    addr_in_range: assert property (@(posedge clock) disable iff (reset)
        wr_en |-> wr_addr <= LAST_ADDR) else $error("mask write address out of range");

    // Average is written in the cycle after its pop
    write_follows_pop: assert property (@(posedge clock) disable iff (reset)
        (pop && state == GS) |=> wr_en)
        else $error("no mask write one cycle after a pop");

    no_adjacent_writes: assert property (@(posedge clock) disable iff (reset)
        wr_en |=> !wr_en) else $error("mask writes on adjacent cycles");

endmodule

// FIFO side only with the writer inputs held quiet
bind pixel_fifo mask_capture_checker u_fifo_checker (
    .clock   (clock),
    .reset   (reset),
    .push    (wr_en),
    .full    (full),
    .pop     (rd_en),
    .empty   (empty),
    .wr_en   (1'b0),
    .wr_addr ('0),
    .state   (mask_ctrl_pkg::IDLE)
);

bind grayscale_mask mask_capture_checker u_writer_checker (
    .clock   (clock),
    .reset   (reset),
    .push    (1'b0),
    .full    (1'b0),
    .pop     (in_rd_en),
    .empty   (in_empty),
    .wr_en   (out_wr_en),
    .wr_addr (out_wr_addr),
    .state   (state)
);

`default_nettype wire

//--- tests/mask_capture_tb.sv
// Testbench for mask_capture_top with LFSR stimulus, reference model, read-back compare and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "mask_defines.svh"

module mask_capture_tb
    import image_pkg::*;
();

    localparam int SIZE            = `MASK_SIZE;
    localparam int ADDR_BITS       = `MASK_ADDR_BITS;
    localparam int FRAMES          = 3;
    localparam int WATCHDOG_CYCLES = FRAMES * SIZE * 8 + 300;  // Frames plus reset and read-back

    logic                 clock = 1'b0;
    logic                 reset;
    logic                 in_wr_en;
    logic [23:0]          in_din;
    logic                 in_full;
    logic [ADDR_BITS-1:0] mask_rd_addr;
    logic [7:0]           mask_rd_data;
    logic                 busy;

    logic [31:0] lfsr = 32'hd6829bc8;
    rgb_pixel_t  frame_pix [0:SIZE-1];  // Pixels of the frame in flight in raster order

    int    value_errors   = 0;
    int    other_errors   = 0;
    int    values_checked = 0;
    int    frames_sent    = 0;
    int    frames_checked = 0;
    int    total_writes   = 0;
    logic  in_frame       = 1'b0;  // Busy must stay high while set
    logic  full_seen      = 1'b0;
    string current_test   = "reset";

    mask_capture_top u_mask_capture_top (
        .clock        (clock),
        .reset        (reset),
        .in_wr_en     (in_wr_en),
        .in_din       (in_din),
        .in_full      (in_full),
        .mask_rd_addr (mask_rd_addr),
        .mask_rd_data (mask_rd_data),
        .busy         (busy)
    );

    always #5 clock = ~clock;

    // Right-shift Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output logic [23:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[22:0], lfsr[0]};  // One step per bit
        end
    endtask

    // Truncated equal-thirds average
    function automatic gray_t reference_gray(input rgb_pixel_t px);
        int sum;
        sum = int'(px.red) + int'(px.green) + int'(px.blue);
        return gray_t'(sum / 3);
    endfunction

    function automatic string frame_name(input int frame);
        case (frame)
            1:       return "frame1_random_gaps";
            2:       return "frame2_back_to_back";
            default: return "frame3_extremes";
        endcase
    endfunction

    // White, black, then one saturated channel in turn
    function automatic rgb_pixel_t extreme_pixel(input int index);
        case (index % 4)
            0: return rgb_pixel_t'(24'hffffff);
            1: return rgb_pixel_t'(24'h000000);
            default: begin
                case ((index / 4) % 3)
                    0:       return rgb_pixel_t'(24'hff0000);
                    1:       return rgb_pixel_t'(24'h00ff00);
                    default: return rgb_pixel_t'(24'h0000ff);
                endcase
            end
        endcase
    endfunction

    task automatic wait_cycle();
        @(negedge clock);
        if (in_frame && !busy) begin
            other_errors++;
            $display("Error: %s busy went low before the frame was written", current_test);
        end
    endtask

    task automatic send_pixel(input rgb_pixel_t px);
        while (in_full) begin  // Hold off the source
            full_seen = 1'b1;
            in_wr_en  = 1'b0;
            wait_cycle();
        end
        in_wr_en = 1'b1;
        in_din   = px;
        wait_cycle();
        in_wr_en = 1'b0;
    endtask

    task automatic send_frame(input int frame);
        logic [23:0] bits;
        rgb_pixel_t  px;
        current_test = frame_name(frame);
        full_seen    = 1'b0;
        for (int i = 0; i < SIZE; i++) begin
            if (frame == 3 && (i % 4) != 3) begin
                px = extreme_pixel(i);
            end else begin
                take_bits(24, bits);
                px = rgb_pixel_t'(bits);
            end
            if (frame == 1) begin
                take_bits(1, bits);
                while (bits[0]) begin  // Random idle gap
                    wait_cycle();
                    take_bits(1, bits);
                end
            end
            frame_pix[i] = px;
            send_pixel(px);
            if (i == 0) begin
                wait_cycle();
                if (!busy) begin
                    other_errors++;
                    $display("Error: %s busy did not rise after the first pixel", current_test);
                end
                in_frame = 1'b1;
            end
        end
        in_frame = 1'b0;
    endtask

    // Mask writes as seen by the memory
    always @(negedge clock) begin
        if (!reset && u_mask_capture_top.mask_wr_en) begin
            total_writes++;
        end
    end

    initial begin : stimulus
        reset    = 1'b1;
        in_wr_en = 1'b0;
        in_din   = '0;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        if (busy || in_full) begin
            other_errors++;
            $display("Error: reset left busy=%b in_full=%b, both should be low", busy, in_full);
        end
        for (int frame = 1; frame <= FRAMES; frame++) begin
            send_frame(frame);
            if (frame == 2 && !full_seen) begin
                other_errors++;
                $display("Error: %s in_full never rose under back-to-back input",
                         current_test);
            end
            frames_sent = frame;
            wait (frames_checked == frame);
        end
        $display("Summary: %0d values checked, %0d value errors, %0d other errors",
                 values_checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : compare
        gray_t expected;
        gray_t actual;
        mask_rd_addr = '0;
        for (int frame = 1; frame <= FRAMES; frame++) begin
            wait (frames_sent >= frame);
            while (busy) @(negedge clock);  // End of frame
            if (total_writes != frame * SIZE) begin
                other_errors++;
                $display("Error: %s busy fell after %0d mask writes, %0d were due",
                         frame_name(frame), total_writes, frame * SIZE);
            end
            mask_rd_addr = '0;
            for (int a = 0; a < SIZE; a++) begin
                @(negedge clock);
                actual   = mask_rd_data;  // Word for address a arrives one clock late
                expected = reference_gray(frame_pix[a]);
                if (a + 1 < SIZE) begin
                    mask_rd_addr = ADDR_BITS'(a + 1);
                end
                if (busy) begin
                    other_errors++;
                    $display("Error: %s busy was high during read-back", frame_name(frame));
                end
                values_checked++;
                if (actual !== expected) begin
                    value_errors++;
                    $display("** Error %s addr %0d: expected %02h, actual %02h",
                             frame_name(frame), a, expected, actual);
                end
            end
            frames_checked = frame;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- mask_capture.f
+incdir+hw
hw/image_pkg.sv
hw/mask_ctrl_pkg.sv
hw/pixel_fifo.sv
hw/grayscale_mask.sv
hw/mask_bram.sv
hw/mask_capture_top.sv
tests/mask_capture_checker.sv
tests/mask_capture_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mask capture testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f mask_capture.f --top-module mask_capture_tb -o sim_mask_capture \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_mask_capture > sim.log 2>&1 \
    || echo "Simulator stopped with an error status" >> sim.log
cat sim.log

grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || { echo "Run ended without a result"; exit 1; }
exit 0
